//--- source/datapath_pkg.sv
package datapath_pkg;

	// data byte
	localparam int data_w = 8;
	typedef logic [data_w-1:0] data_t;

	// field memory pointer, 32 entries
	localparam int field_ptr_w = 5;
	typedef logic [field_ptr_w-1:0] field_ptr_t;

	localparam int instr_w = 20;
	typedef logic [instr_w-1:0] instr_t;

	// input and output ports
	localparam int port_count = 8;
	localparam int port_sel_w = $clog2(port_count);
	typedef logic [port_sel_w-1:0] port_sel_t;

endpackage

//--- source/isa_pkg.sv
package isa_pkg;

	// instruction layout: fieldp | cond | field op | op8 | imm8
	localparam int fieldp_lsb = 15;
	localparam int field_op_bit = 12;
	localparam int op8_lsb = 8;
	localparam int op3_lsb = 4; // i3 opcode lives in the imm8 slot
	localparam int op0_lsb = 0;
	localparam int op_w = 4;
	localparam int imm3_w = 3; // i3 immediate, bits 2..0

	typedef logic [op_w-1:0] opcode_t;

	// all ones escapes to the next, smaller opcode space
	localparam opcode_t i3_prefix = 4'b1111;
	localparam opcode_t i0_prefix = 4'b1111;

	// i8 space
	localparam opcode_t op_or = 4'b0000;
	localparam opcode_t op_and = 4'b0001;
	localparam opcode_t op_add = 4'b0100;
	localparam opcode_t op_sub = 4'b0101;
	localparam opcode_t op_ldi = 4'b0110;

	// i3 space
	localparam opcode_t op_shl = 4'b0000;
	localparam opcode_t op_shr = 4'b0010;
	localparam opcode_t op_asr = 4'b0011;
	localparam opcode_t op_in = 4'b0101;
	localparam opcode_t op_out = 4'b1000;

	// i0 space
	localparam opcode_t op_not = 4'b0000;
	localparam opcode_t op_ldba = 4'b0001;
	localparam opcode_t op_stab = 4'b0100;
	localparam opcode_t op_nop = 4'b0101;

	// pointer 0, cond 0, acc op, then the two prefixes and nop
	localparam datapath_pkg::instr_t nop_instr = {8'h00, i3_prefix, i0_prefix, op_nop};

	// function picked by decode, shared by both ALUs
	typedef logic [2:0] alu_op_t;
	localparam alu_op_t alu_or = 3'd0;
	localparam alu_op_t alu_and = 3'd1;
	localparam alu_op_t alu_add = 3'd2;
	localparam alu_op_t alu_sub = 3'd3;
	localparam alu_op_t alu_not = 3'd4;
	localparam alu_op_t alu_shl = 3'd5;
	localparam alu_op_t alu_shr = 3'd6;
	localparam alu_op_t alu_asr = 3'd7;

endpackage

//--- source/exec_if.sv
interface exec_if;

	isa_pkg::alu_op_t alu_op;
	datapath_pkg::data_t imm; // imm8, or zero-extended imm3
	logic use_alu;
	logic load_imm; // ldi
	logic load_in; // in
	logic load_field; // ldba
	logic store_acc; // stab
	logic dest_acc;
	logic dest_field;
	logic do_out;
	datapath_pkg::field_ptr_t fieldp; // pointer of the instruction in stage three

	modport decoder (output alu_op, imm, use_alu, load_imm, load_in, load_field, store_acc,
		dest_acc, dest_field, do_out, fieldp);

	modport acc_side (input alu_op, imm, use_alu, load_imm, load_in, load_field);

	modport field_side (input alu_op, imm, use_alu, load_imm, store_acc);

	modport writeback (input dest_acc, dest_field, do_out, imm, fieldp);

endinterface

//--- source/alu.sv
module alu
(
	input datapath_pkg::data_t i_a,
	input datapath_pkg::data_t i_b,
	input isa_pkg::alu_op_t i_op,
	output datapath_pkg::data_t o_y
);

	logic subtract;
	datapath_pkg::data_t b_addend;
	datapath_pkg::data_t sum;
	logic [isa_pkg::imm3_w-1:0] shamt;

	// one adder, sub is a + ~b + 1
	assign subtract = (i_op == isa_pkg::alu_sub);
	assign b_addend = subtract ? ~i_b : i_b;
	assign sum = i_a + b_addend + datapath_pkg::data_t'(subtract); // wraps mod 256

	assign shamt = i_b[isa_pkg::imm3_w-1:0];

	always_comb
	begin
		case (i_op)
			isa_pkg::alu_or: o_y = i_a | i_b;
			isa_pkg::alu_and: o_y = i_a & i_b;
			isa_pkg::alu_add: o_y = sum;
			isa_pkg::alu_sub: o_y = sum;
			isa_pkg::alu_not: o_y = ~i_a;
			isa_pkg::alu_shl: o_y = i_a << shamt;
			isa_pkg::alu_shr: o_y = i_a >> shamt;
			isa_pkg::alu_asr: o_y = datapath_pkg::data_t'($signed(i_a) >>> shamt); // keeps sign
		endcase
	end

endmodule

//--- source/instr_decoder.sv
module instr_decoder
(
	input logic clk,
	input logic reset,
	input datapath_pkg::instr_t i_instruction,
	output datapath_pkg::field_ptr_t o_fieldp,
	exec_if.decoder ex
);

	datapath_pkg::instr_t ir;
	isa_pkg::opcode_t op8;
	isa_pkg::opcode_t op3;
	isa_pkg::opcode_t op0;
	logic field_op;
	logic is_i8;
	logic is_i3;
	logic is_i0;
	isa_pkg::alu_op_t alu_op;
	logic use_alu;
	logic load_imm;
	logic load_in;
	logic load_field;
	logic store_acc;
	logic do_out;
	logic dest_acc;
	logic dest_field;
	datapath_pkg::data_t imm;

	// stage one
	always_ff @(posedge clk)
	begin
		if (reset)
			ir <= isa_pkg::nop_instr;
		else
			ir <= i_instruction;
	end

	assign o_fieldp = ir[isa_pkg::fieldp_lsb +: datapath_pkg::field_ptr_w];

	assign field_op = ir[isa_pkg::field_op_bit];
	assign op8 = ir[isa_pkg::op8_lsb +: isa_pkg::op_w];
	assign op3 = ir[isa_pkg::op3_lsb +: isa_pkg::op_w];
	assign op0 = ir[isa_pkg::op0_lsb +: isa_pkg::op_w];

	assign is_i8 = (op8 != isa_pkg::i3_prefix);
	assign is_i3 = !is_i8 && (op3 != isa_pkg::i0_prefix);
	assign is_i0 = !is_i8 && !is_i3;

	assign imm = is_i8 ? ir[datapath_pkg::data_w-1:0] :
		{{(datapath_pkg::data_w - isa_pkg::imm3_w){1'b0}}, ir[isa_pkg::imm3_w-1:0]};

	// unknown or dropped opcodes fall through to nop
	always_comb
	begin
		alu_op = isa_pkg::alu_or;
		use_alu = 1'b0;
		load_imm = 1'b0;
		load_in = 1'b0;
		load_field = 1'b0;
		store_acc = 1'b0;
		do_out = 1'b0;
		if (is_i8)
		begin
			case (op8)
				isa_pkg::op_or: {use_alu, alu_op} = {1'b1, isa_pkg::alu_or};
				isa_pkg::op_and: {use_alu, alu_op} = {1'b1, isa_pkg::alu_and};
				isa_pkg::op_add: {use_alu, alu_op} = {1'b1, isa_pkg::alu_add};
				isa_pkg::op_sub: {use_alu, alu_op} = {1'b1, isa_pkg::alu_sub};
				isa_pkg::op_ldi: load_imm = 1'b1;
				default: ;
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				isa_pkg::op_shl: {use_alu, alu_op} = {1'b1, isa_pkg::alu_shl};
				isa_pkg::op_shr: {use_alu, alu_op} = {1'b1, isa_pkg::alu_shr};
				isa_pkg::op_asr: {use_alu, alu_op} = {1'b1, isa_pkg::alu_asr};
				isa_pkg::op_in: load_in = 1'b1;
				isa_pkg::op_out: do_out = 1'b1;
				default: ;
			endcase
		end
		else if (is_i0)
		begin
			case (op0)
				isa_pkg::op_not: {use_alu, alu_op} = {1'b1, isa_pkg::alu_not};
				isa_pkg::op_ldba: load_field = 1'b1;
				isa_pkg::op_stab: store_acc = 1'b1;
				default: ;
			endcase
		end
	end

	// alu ops and ldi follow the field-op bit, the transfers have a fixed target
	assign dest_acc = ((use_alu || load_imm) && !field_op) || load_in || load_field;
	assign dest_field = ((use_alu || load_imm) && field_op) || store_acc;

	// stage two
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ex.use_alu <= 1'b0;
			ex.load_imm <= 1'b0;
			ex.load_in <= 1'b0;
			ex.load_field <= 1'b0;
			ex.store_acc <= 1'b0;
			ex.dest_acc <= 1'b0;
			ex.dest_field <= 1'b0;
			ex.do_out <= 1'b0;
		end
		else
		begin
			ex.use_alu <= use_alu;
			ex.load_imm <= load_imm;
			ex.load_in <= load_in;
			ex.load_field <= load_field;
			ex.store_acc <= store_acc;
			ex.dest_acc <= dest_acc;
			ex.dest_field <= dest_field;
			ex.do_out <= do_out;
		end
	end

	always_ff @(posedge clk)
	begin
		ex.alu_op <= alu_op;
		ex.imm <= imm;
		ex.fieldp <= o_fieldp; // becomes the write pointer
	end

endmodule

//--- source/acc_path.sv
module acc_path
(
	input datapath_pkg::data_t i_acc,
	input datapath_pkg::data_t i_field_value,
	input datapath_pkg::data_t i_inputs [datapath_pkg::port_count],
	exec_if.acc_side ex,
	output datapath_pkg::data_t o_acc_next
);

	datapath_pkg::data_t alu_y;
	datapath_pkg::port_sel_t in_sel;

	// operand a is always the accumulator here
	alu u_alu
	(
		.i_a(i_acc),
		.i_b(ex.imm),
		.i_op(ex.alu_op),
		.o_y(alu_y)
	);

	assign in_sel = ex.imm[datapath_pkg::port_sel_w-1:0];

	assign o_acc_next = ex.load_imm ? ex.imm : // ldi
		ex.load_in ? i_inputs[in_sel] : // in
		ex.load_field ? i_field_value : // ldba
		ex.use_alu ? alu_y : i_acc;

endmodule

//--- source/field_path.sv
module field_path
(
	input logic clk,
	input logic reset,
	input datapath_pkg::data_t i_field_in,
	input datapath_pkg::data_t i_acc,
	exec_if.field_side ex,
	output datapath_pkg::data_t o_field_value,
	output datapath_pkg::data_t o_field_next
);

	datapath_pkg::data_t alu_y;

	// byte returned by the field memory for the instruction entering stage two
	always_ff @(posedge clk)
	begin
		if (reset)
			o_field_value <= '0;
		else
			o_field_value <= i_field_in;
	end

	alu u_alu
	(
		.i_a(o_field_value),
		.i_b(ex.imm),
		.i_op(ex.alu_op),
		.o_y(alu_y)
	);

	assign o_field_next = ex.load_imm ? ex.imm : // ldi
		ex.store_acc ? i_acc : // stab
		ex.use_alu ? alu_y : o_field_value;

endmodule

//--- source/writeback_unit.sv
module writeback_unit
(
	input logic clk,
	input logic reset,
	input datapath_pkg::data_t i_acc_next,
	input datapath_pkg::data_t i_field_next,
	exec_if.writeback ex,
	output datapath_pkg::data_t o_acc,
	output datapath_pkg::data_t o_field_out,
	output datapath_pkg::field_ptr_t o_fieldwp,
	output logic o_field_write_en,
	output datapath_pkg::data_t o_outputs [datapath_pkg::port_count]
);

	datapath_pkg::port_sel_t out_sel;

	assign out_sel = ex.imm[datapath_pkg::port_sel_w-1:0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc <= '0;
			o_field_out <= '0;
			o_fieldwp <= '0;
			o_field_write_en <= 1'b0;
			o_outputs <= '{default: '0};
		end
		else
		begin
			o_field_write_en <= ex.dest_field; // one cycle per write
			if (ex.dest_acc)
				o_acc <= i_acc_next;
			if (ex.dest_field)
			begin
				o_field_out <= i_field_next;
				o_fieldwp <= ex.fieldp;
			end
			// acc as left by all earlier instructions
			if (ex.do_out)
				o_outputs[out_sel] <= o_acc;
		end
	end

endmodule

//--- source/pattern_core.sv
module pattern_core
(
	input logic clk,
	input logic reset,
	input datapath_pkg::instr_t i_instruction,
	input datapath_pkg::data_t i_field_in,
	input datapath_pkg::data_t i_inputs [datapath_pkg::port_count],
	output datapath_pkg::field_ptr_t o_fieldp,
	output datapath_pkg::field_ptr_t o_fieldwp,
	output datapath_pkg::data_t o_field_out,
	output logic o_field_write_en,
	output datapath_pkg::data_t o_acc,
	output datapath_pkg::data_t o_outputs [datapath_pkg::port_count]
);

	datapath_pkg::data_t acc_next;
	datapath_pkg::data_t field_next;
	datapath_pkg::data_t field_value; // latched field byte, also feeds ldba

	exec_if ex ();

	instr_decoder u_decoder
	(
		.clk(clk),
		.reset(reset),
		.i_instruction(i_instruction),
		.o_fieldp(o_fieldp),
		.ex(ex.decoder)
	);

	acc_path u_acc_path
	(
		.i_acc(o_acc),
		.i_field_value(field_value),
		.i_inputs(i_inputs),
		.ex(ex.acc_side),
		.o_acc_next(acc_next)
	);

	field_path u_field_path
	(
		.clk(clk),
		.reset(reset),
		.i_field_in(i_field_in),
		.i_acc(o_acc),
		.ex(ex.field_side),
		.o_field_value(field_value),
		.o_field_next(field_next)
	);

	writeback_unit u_writeback
	(
		.clk(clk),
		.reset(reset),
		.i_acc_next(acc_next),
		.i_field_next(field_next),
		.ex(ex.writeback),
		.o_acc(o_acc),
		.o_field_out(o_field_out),
		.o_fieldwp(o_fieldwp),
		.o_field_write_en(o_field_write_en),
		.o_outputs(o_outputs)
	);

endmodule

//--- tests/pattern_core_tb.sv
module pattern_core_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk = 1'b0;
	logic reset;
	datapath_pkg::instr_t instruction;
	datapath_pkg::data_t field_in = '0;
	datapath_pkg::data_t inputs [datapath_pkg::port_count];
	datapath_pkg::field_ptr_t fieldp;
	datapath_pkg::field_ptr_t fieldwp;
	datapath_pkg::data_t field_out;
	logic field_write_en;
	datapath_pkg::data_t acc;
	datapath_pkg::data_t outputs [datapath_pkg::port_count];

	// field memory model with one-cycle preset requests
	datapath_pkg::data_t field_mem [32];
	logic preset_en;
	datapath_pkg::field_ptr_t preset_ptr;
	datapath_pkg::data_t preset_val;

	// stimulus table as one queue per column
	string row_name [$];
	datapath_pkg::instr_t row_instr [$];
	datapath_pkg::data_t row_preset [$];
	datapath_pkg::data_t row_acc [$];
	logic row_wr [$];
	datapath_pkg::data_t row_field [$];
	int row_port [$]; // -1 when no output port changes
	datapath_pkg::data_t row_out [$];
	datapath_pkg::data_t exp_outputs [datapath_pkg::port_count];

	logic [31:0] rng;

	pattern_core UUT
	(
		.clk(clk),
		.reset(reset),
		.i_instruction(instruction),
		.i_field_in(field_in),
		.i_inputs(inputs),
		.o_fieldp(fieldp),
		.o_fieldwp(fieldwp),
		.o_field_out(field_out),
		.o_field_write_en(field_write_en),
		.o_acc(acc),
		.o_outputs(outputs)
	);

	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		field_in <= field_mem[fieldp]; // byte for the pointer shown since the last edge
		if (reset)
		begin
			for (int a = 0; a < 32; a++)
				field_mem[datapath_pkg::field_ptr_t'(a)] <= datapath_pkg::data_t'(a * 37 + 11);
		end
		else
		begin
			if (preset_en)
				field_mem[preset_ptr] <= preset_val;
			if (field_write_en)
				field_mem[fieldwp] <= field_out;
		end
	end

	function automatic datapath_pkg::instr_t encode_i8(input datapath_pkg::field_ptr_t ptr,
		input logic fop, input isa_pkg::opcode_t op, input datapath_pkg::data_t imm);
		return {ptr, 2'b00, fop, op, imm};
	endfunction

	function automatic datapath_pkg::instr_t encode_i3(input datapath_pkg::field_ptr_t ptr,
		input logic fop, input isa_pkg::opcode_t op, input logic [2:0] imm3);
		return {ptr, 2'b00, fop, isa_pkg::i3_prefix, op, 1'b0, imm3};
	endfunction

	function automatic datapath_pkg::instr_t encode_i0(input datapath_pkg::field_ptr_t ptr,
		input logic fop, input isa_pkg::opcode_t op);
		return {ptr, 2'b00, fop, isa_pkg::i3_prefix, isa_pkg::i0_prefix, op};
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// in-order accumulator model for the burst
	// kinds 0 to 4 are i8 ops and 5 to 7 are shifts
	function automatic datapath_pkg::data_t expected_acc(input int kind,
		input datapath_pkg::data_t a, input datapath_pkg::data_t imm);
		datapath_pkg::data_t r;
		case (kind)
			0: r = a | imm;
			1: r = a & imm;
			2: r = a + imm; // mod 256
			3: r = a - imm;
			4: r = imm;
			5: r = a << imm[2:0];
			6: r = a >> imm[2:0];
			default: r = (a >> imm[2:0]) | (a[7] ? ~(8'hFF >> imm[2:0]) : 8'h00); // sign fill
		endcase
		return r;
	endfunction

	function automatic datapath_pkg::instr_t encode_random(input int kind,
		input datapath_pkg::field_ptr_t ptr, input datapath_pkg::data_t imm);
		case (kind)
			0: return encode_i8(ptr, 1'b0, isa_pkg::op_or, imm);
			1: return encode_i8(ptr, 1'b0, isa_pkg::op_and, imm);
			2: return encode_i8(ptr, 1'b0, isa_pkg::op_add, imm);
			3: return encode_i8(ptr, 1'b0, isa_pkg::op_sub, imm);
			4: return encode_i8(ptr, 1'b0, isa_pkg::op_ldi, imm);
			5: return encode_i3(ptr, 1'b0, isa_pkg::op_shl, imm[2:0]);
			6: return encode_i3(ptr, 1'b0, isa_pkg::op_shr, imm[2:0]);
			default: return encode_i3(ptr, 1'b0, isa_pkg::op_asr, imm[2:0]);
		endcase
	endfunction

	task automatic check_equal(input string test, input datapath_pkg::data_t expected,
		input datapath_pkg::data_t actual);
		if (actual !== expected)
		begin
			$display("FAIL %s: expected 0x%02h, actual 0x%02h", test, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "value mismatch in %s", test);
		end
	endtask

	task automatic check_ports(input string test);
		datapath_pkg::port_sel_t sel;
		for (int k = 0; k < datapath_pkg::port_count; k++)
		begin
			sel = datapath_pkg::port_sel_t'(k);
			check_equal($sformatf("%s port %0d", test, k), exp_outputs[sel], outputs[sel]);
		end
	endtask

	task automatic add_row(input string name, input datapath_pkg::instr_t instr,
		input datapath_pkg::data_t preset, input datapath_pkg::data_t exp_acc,
		input logic exp_wr, input datapath_pkg::data_t exp_field, input int port,
		input datapath_pkg::data_t out_val);
		row_name.push_back(name);
		row_instr.push_back(instr);
		row_preset.push_back(preset);
		row_acc.push_back(exp_acc);
		row_wr.push_back(exp_wr);
		row_field.push_back(exp_field);
		row_port.push_back(port);
		row_out.push_back(out_val);
	endtask

	// accumulator row without field write or port change
	task automatic add_acc_row(input string name, input datapath_pkg::instr_t instr,
		input datapath_pkg::data_t exp_acc);
		add_row(name, instr, 8'hEE, exp_acc, 1'b0, 8'h00, -1, 8'h00);
	endtask

	task automatic load_table();
		add_acc_row("ldi", encode_i8(5'd1, 1'b0, isa_pkg::op_ldi, 8'h5A), 8'h5A);
		add_acc_row("or", encode_i8(5'd2, 1'b0, isa_pkg::op_or, 8'h81), 8'hDB);
		add_acc_row("and", encode_i8(5'd3, 1'b0, isa_pkg::op_and, 8'h0F), 8'h0B);
		add_acc_row("add", encode_i8(5'd4, 1'b0, isa_pkg::op_add, 8'h30), 8'h3B);
		add_acc_row("add_wrap", encode_i8(5'd5, 1'b0, isa_pkg::op_add, 8'hF0), 8'h2B);
		add_acc_row("sub", encode_i8(5'd6, 1'b0, isa_pkg::op_sub, 8'h0B), 8'h20);
		add_acc_row("sub_wrap", encode_i8(5'd7, 1'b0, isa_pkg::op_sub, 8'h21), 8'hFF);
		add_acc_row("not", encode_i0(5'd8, 1'b0, isa_pkg::op_not), 8'h00);
		add_acc_row("ldi_b", encode_i8(5'd9, 1'b0, isa_pkg::op_ldi, 8'h96), 8'h96);
		add_acc_row("shl", encode_i3(5'd10, 1'b0, isa_pkg::op_shl, 3'd3), 8'hB0);
		add_acc_row("shr", encode_i3(5'd11, 1'b0, isa_pkg::op_shr, 3'd2), 8'h2C);
		add_acc_row("ldi_neg", encode_i8(5'd12, 1'b0, isa_pkg::op_ldi, 8'h84), 8'h84);
		add_acc_row("asr_neg", encode_i3(5'd13, 1'b0, isa_pkg::op_asr, 3'd2), 8'hE1);
		// field side leaves acc at E1
		add_row("field_ldi", encode_i8(5'd3, 1'b1, isa_pkg::op_ldi, 8'h3C),
			8'h11, 8'hE1, 1'b1, 8'h3C, -1, 8'h00);
		add_row("field_add", encode_i8(5'd7, 1'b1, isa_pkg::op_add, 8'h25),
			8'h40, 8'hE1, 1'b1, 8'h65, -1, 8'h00);
		add_row("field_shl", encode_i3(5'd12, 1'b1, isa_pkg::op_shl, 3'd1),
			8'hC3, 8'hE1, 1'b1, 8'h86, -1, 8'h00);
		add_row("ldba", encode_i0(5'd20, 1'b0, isa_pkg::op_ldba),
			8'h77, 8'h77, 1'b0, 8'h00, -1, 8'h00);
		add_row("ldba_fop", encode_i0(5'd9, 1'b1, isa_pkg::op_ldba),
			8'h3D, 8'h3D, 1'b0, 8'h00, -1, 8'h00);
		add_row("stab", encode_i0(5'd25, 1'b0, isa_pkg::op_stab),
			8'h00, 8'h3D, 1'b1, 8'h3D, -1, 8'h00);
		// inputs hold 0x50 + port
		add_acc_row("in", encode_i3(5'd2, 1'b0, isa_pkg::op_in, 3'd5), 8'h55);
		add_row("out_2", encode_i3(5'd4, 1'b0, isa_pkg::op_out, 3'd2),
			8'hEE, 8'h55, 1'b0, 8'h00, 2, 8'h55);
		add_acc_row("ldi_c", encode_i8(5'd6, 1'b0, isa_pkg::op_ldi, 8'hA7), 8'hA7);
		add_row("out_6", encode_i3(5'd8, 1'b0, isa_pkg::op_out, 3'd6),
			8'hEE, 8'hA7, 1'b0, 8'h00, 6, 8'hA7);
		add_acc_row("nop", encode_i0(5'd4, 1'b0, isa_pkg::op_nop), 8'hA7);
	endtask

	// memory answers one edge after a pointer shows so the nops carry the row's pointer
	task automatic run_row(input int r);
		datapath_pkg::field_ptr_t ptr;
		int waited;
		string name;
		name = row_name[r];
		ptr = row_instr[r][isa_pkg::fieldp_lsb +: datapath_pkg::field_ptr_w];
		@(posedge clk);
		preset_en <= 1'b1;
		preset_ptr <= ptr;
		preset_val <= row_preset[r];
		instruction <= encode_i0(ptr, 1'b0, isa_pkg::op_nop);
		@(posedge clk);
		preset_en <= 1'b0;
		instruction <= row_instr[r];
		@(posedge clk);
		instruction <= encode_i0(ptr, 1'b0, isa_pkg::op_nop);
		@(posedge clk);
		check_equal({name, " field pointer"}, datapath_pkg::data_t'(ptr),
			datapath_pkg::data_t'(fieldp));
		if (row_wr[r])
		begin
			waited = 0;
			while (field_write_en !== 1'b1)
			begin
				if (waited == 10)
				begin
					$display("timeout: no field write within 10 cycles in %s", name);
					$display(">>> FAIL");
					$fatal(1, "field write timeout");
				end
				@(posedge clk);
				waited++;
			end
			check_equal({name, " field value"}, row_field[r], field_out);
			check_equal({name, " write pointer"}, datapath_pkg::data_t'(ptr),
				datapath_pkg::data_t'(fieldwp));
			@(posedge clk);
			check_equal({name, " write pulse"}, 8'h00, datapath_pkg::data_t'(field_write_en));
			check_equal({name, " field memory"}, row_field[r], field_mem[ptr]);
		end
		else
		begin
			repeat (3)
			begin
				@(posedge clk);
				check_equal({name, " no write"}, 8'h00, datapath_pkg::data_t'(field_write_en));
			end
		end
		check_equal({name, " acc"}, row_acc[r], acc);
		if (row_port[r] >= 0)
			exp_outputs[datapath_pkg::port_sel_t'(row_port[r])] = row_out[r];
		check_ports(name);
	endtask

	initial
	begin
		datapath_pkg::port_sel_t sel;
		datapath_pkg::data_t model;
		int kind;
		reset <= 1'b1;
		instruction <= encode_i0(5'd0, 1'b0, isa_pkg::op_nop);
		preset_en <= 1'b0;
		preset_ptr <= '0;
		preset_val <= '0;
		for (int k = 0; k < datapath_pkg::port_count; k++)
		begin
			sel = datapath_pkg::port_sel_t'(k);
			inputs[sel] <= datapath_pkg::data_t'(8'h50 + k);
			exp_outputs[sel] = 8'h00;
		end
		load_table();
		rng = 32'd56350;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		// idle nops after reset
		repeat (5)
		begin
			@(posedge clk);
			check_equal("reset no write", 8'h00, datapath_pkg::data_t'(field_write_en));
		end
		check_equal("reset acc", 8'h00, acc);
		check_equal("reset field pointer", 8'h00, datapath_pkg::data_t'(fieldp));
		check_equal("reset write pointer", 8'h00, datapath_pkg::data_t'(fieldwp));
		check_equal("reset field out", 8'h00, field_out);
		check_ports("reset");

		for (int r = 0; r < row_name.size(); r++)
			run_row(r);

		// back to back burst with three in flight
		model = row_acc[row_acc.size() - 1];
		for (int i = 0; i < 32; i++)
		begin
			rng = xorshift32(rng);
			kind = int'(rng[2:0]);
			@(posedge clk);
			instruction <= encode_random(kind, rng[20:16], rng[15:8]);
			model = expected_acc(kind, model, rng[15:8]);
		end
		@(posedge clk);
		instruction <= encode_i0(5'd0, 1'b0, isa_pkg::op_nop);
		repeat (4) @(posedge clk);
		check_equal("burst acc", model, acc);

		$display(">>> PASS");
		$finish;
	end

endmodule

//--- all.f
source/datapath_pkg.sv
source/isa_pkg.sv
source/exec_if.sv
source/alu.sv
source/instr_decoder.sv
source/acc_path.sv
source/field_path.sv
source/writeback_unit.sv
source/pattern_core.sv
tests/pattern_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the pattern_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f all.f --top-module pattern_core_tb --Mdir obj_dir -o pattern_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/pattern_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0
